// ==== files.f ====
+incdir+design
design/lsu_pkg.sv
design/store_if.sv
design/uc_store_formatter.sv
design/store_requestor.sv
design/ext_write_port.sv
design/store_out_unit.sv
bench/store_out_asserts.sv
bench/store_out_tb.sv

// ==== Makefile ====
# Verilator build and run for the store-out unit

VERILATOR ?= verilator
TOP       ?= store_out_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard design/*.sv design/*.svh bench/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/store_out_tb.sv ====
`timescale 1ns/1ns
`include "lsu_macros.svh"

module store_out_tb
  import lsu_pkg::*;
();

  localparam int N_RAND      = 80;             // random phase requests
  localparam int N_DIRECTED  = 3;
  localparam int CYCLE_LIMIT = 20 * (N_RAND + N_DIRECTED);

  typedef struct packed {
    logic [31:0] addr;
    logic [63:0] data;
    logic [7:0]  be;
    logic        last;
  } beat_t;

  logic                     i_clk;
  logic                     i_reset_n;
  logic                     i_uc_valid;
  logic                     o_uc_ready;
  logic [`PADDR_W-1:0]      i_uc_paddr;
  logic [`XLEN_W-1:0]       i_uc_data;
  mem_size_e                i_uc_size;
  logic                     i_evict_valid;
  logic                     o_evict_ready;
  logic [`PADDR_W-1:0]      i_evict_paddr;
  logic [`LINE_W-1:0]       i_evict_data;
  logic                     i_fwd_valid;
  logic [`PADDR_W-1:0]      i_fwd_paddr;
  logic                     o_fwd_hit;
  logic [`XLEN_W-1:0]       o_fwd_data;
  logic [`XLEN_W/8-1:0]     o_fwd_be;
  logic                     i_snoop_valid;
  logic [`PADDR_W-1:0]      i_snoop_paddr;
  logic                     o_snoop_resp_valid;
  logic [`LINE_W-1:0]       o_snoop_resp_data;
  logic [`LINE_BYTES-1:0]   o_snoop_resp_be;
  logic                     o_wr_valid;
  wr_src_e                  o_wr_src;
  logic [`PADDR_W-1:0]      o_wr_addr;
  logic [`BEAT_W-1:0]       o_wr_data;
  logic [`BEAT_W/8-1:0]     o_wr_be;
  logic                     o_wr_last;
  logic                     i_wr_ready;

  logic [31:0] lfsr = 32'd95;
  beat_t       q_evict[$];
  beat_t       q_uc[$];
  wr_src_e     src_log[$];
  logic        ev_fire;
  logic        uc_fire;
  int          err_value;
  int          err_other;
  int          cycles;
  int          n_issued;

  store_out_unit DUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // Galois LFSR stepped once per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr ^= 32'h8020_0003;
      v = {v[62:0], b};
    end
    return v;
  endfunction

  task automatic report_value(input string name, input logic [127:0] exp,
                              input logic [127:0] got);
    $display("Fail %s expected %h got %h", name, exp, got);
    err_value++;
  endtask

  task automatic report_other(input string what);
    $display("%s", what);
    err_other++;
  endtask

  // ---------------------------------------------------------------------
  // reference model
  // ---------------------------------------------------------------------
  task automatic push_evict(input logic [31:0] paddr, input logic [127:0] data);
    beat_t bt;
    for (int b = 0; b < 2; b++) begin
      bt.addr = {paddr[31:4], 4'h0} + 32'(8 * b);
      bt.data = data[64*b +: 64];
      bt.be   = 8'hff;
      bt.last = (b == 1);
      q_evict.push_back(bt);
    end
  endtask

  task automatic push_uc(input logic [31:0] paddr, input logic [63:0] data,
                         input mem_size_e size);
    beat_t        bt;
    logic [15:0]  be_line;
    logic [127:0] data_line;
    logic [3:0]   ofs;
    int           beat;
    ofs       = paddr[3:0];
    be_line   = 16'((1 << (1 << int'(size))) - 1) << ofs;
    data_line = {64'd0, data} << (8 * ofs);
    beat      = ofs[3];           // aligned store fits one beat
    bt.addr = {paddr[31:4], 4'h0} + 32'(8 * beat);
    bt.data = data_line[64*beat +: 64];
    bt.be   = be_line[8*beat +: 8];
    bt.last = 1'b1;
    q_uc.push_back(bt);
  endtask

  task automatic check_beat();
    beat_t exp;
    if (o_wr_src == SRC_EVICT && q_evict.size() == 0) begin
      report_other("eviction beat seen with no eviction pending");
      return;
    end
    if (o_wr_src == SRC_UC && q_uc.size() == 0) begin
      report_other("uncached beat seen with no store pending");
      return;
    end
    exp = (o_wr_src == SRC_EVICT) ? q_evict.pop_front() : q_uc.pop_front();
    assert (o_wr_addr == exp.addr) else report_value("o_wr_addr", exp.addr, o_wr_addr);
    assert (o_wr_data == exp.data) else report_value("o_wr_data", exp.data, o_wr_data);
    assert (o_wr_be == exp.be) else report_value("o_wr_be", exp.be, o_wr_be);
    assert (o_wr_last == exp.last) else report_value("o_wr_last", exp.last, o_wr_last);
    src_log.push_back(o_wr_src);
  endtask

  always @(posedge i_clk) begin
    ev_fire = i_reset_n && i_evict_valid && o_evict_ready;
    uc_fire = i_reset_n && i_uc_valid && o_uc_ready;
    if (ev_fire) push_evict(i_evict_paddr, i_evict_data);
    if (uc_fire) push_uc(i_uc_paddr, i_uc_data, i_uc_size);
    if (i_reset_n && o_wr_valid && i_wr_ready) check_beat();
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, requests still outstanding", cycles);
      $display("errors: %0d value, %0d other", err_value, err_other);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ---------------------------------------------------------------------
  // stimulus helpers
  // ---------------------------------------------------------------------
  task automatic wait_drive();
    @(posedge i_clk);
    #10;
  endtask

  task automatic send_evict(input logic [31:0] paddr, input logic [127:0] data);
    i_evict_valid = 1'b1;
    i_evict_paddr = paddr;
    i_evict_data  = data;
    do wait_drive(); while (!ev_fire);
    i_evict_valid = 1'b0;
  endtask

  task automatic send_uc(input logic [31:0] paddr, input logic [63:0] data,
                         input mem_size_e size);
    i_uc_valid = 1'b1;
    i_uc_paddr = paddr;
    i_uc_data  = data;
    i_uc_size  = size;
    do wait_drive(); while (!uc_fire);
    i_uc_valid = 1'b0;
  endtask

  task automatic check_fwd(input logic [31:0] addr, input logic exp_hit,
                           input logic [63:0] exp_data);
    i_fwd_valid = 1'b1;
    i_fwd_paddr = addr;
    #5;
    assert (o_fwd_hit == exp_hit) else report_value("o_fwd_hit", exp_hit, o_fwd_hit);
    assert (o_fwd_be == {8{exp_hit}}) else report_value("o_fwd_be", {8{exp_hit}}, o_fwd_be);
    if (exp_hit) begin
      assert (o_fwd_data == exp_data) else report_value("o_fwd_data", exp_data, o_fwd_data);
    end
    wait_drive();
    i_fwd_valid = 1'b0;
  endtask

  task automatic check_snoop(input logic [31:0] addr, input logic exp_hit,
                             input logic [127:0] exp_data);
    i_snoop_valid = 1'b1;
    i_snoop_paddr = addr;
    wait_drive();
    i_snoop_valid = 1'b0;
    #1;
    assert (o_snoop_resp_valid) else report_other("snoop response missing");
    assert (o_snoop_resp_be == {16{exp_hit}})
      else report_value("o_snoop_resp_be", {16{exp_hit}}, o_snoop_resp_be);
    if (exp_hit) begin
      assert (o_snoop_resp_data == exp_data)
        else report_value("o_snoop_resp_data", exp_data, o_snoop_resp_data);
    end
  endtask

  task automatic drain();
    i_wr_ready = 1'b1;
    while (q_evict.size() != 0 || q_uc.size() != 0 || o_wr_valid) wait_drive();
  endtask

  // ---------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------
  initial begin
    logic [127:0] data_a;
    logic [127:0] data_b;
    logic [3:0]   ofs;
    mem_size_e    sz;
    err_value = 0;
    err_other = 0;
    cycles    = 0;
    n_issued  = 0;
    i_reset_n = 1'b0;
    i_uc_valid = 1'b0;
    i_uc_paddr = '0;
    i_uc_data  = '0;
    i_uc_size  = SIZE_B;
    i_evict_valid = 1'b0;
    i_evict_paddr = '0;
    i_evict_data  = '0;
    i_fwd_valid   = 1'b0;
    i_fwd_paddr   = '0;
    i_snoop_valid = 1'b0;
    i_snoop_paddr = '0;
    i_wr_ready    = 1'b0;
    repeat (10) @(posedge i_clk);
    #10;
    i_reset_n = 1'b1;
    #1;
    assert (!o_wr_valid && !o_snoop_resp_valid && !o_fwd_hit)
      else report_other("outputs not idle after reset");
    assert (o_evict_ready && o_uc_ready) else report_other("inputs not ready after reset");
    wait_drive();

    // stalled port holding one eviction with another waiting
    data_a = {rand_bits(64), rand_bits(64)};
    data_b = {rand_bits(64), rand_bits(64)};
    send_evict(32'h0000_1000, data_a);
    while (!o_wr_valid) wait_drive();
    send_evict(32'h0000_2340, data_b);
    send_uc(32'h0000_3008, rand_bits(64), SIZE_W);
    repeat (3) wait_drive();
    assert (!o_evict_ready) else report_other("eviction ready while slot full");
    check_fwd(32'h0000_2348, 1'b1, 64'(data_b >> 64));
    check_fwd(32'h0000_2343, 1'b1, 64'(data_b >> 24));
    check_fwd(32'h0000_1000, 1'b0, '0);
    check_fwd(32'h0000_5000, 1'b0, '0);
    check_snoop(32'h0000_2340, 1'b1, data_b);
    check_snoop(32'h0000_1008, 1'b0, '0);
    check_snoop(32'h0000_7770, 1'b0, '0);
    src_log.delete();
    drain();
    assert (src_log.size() == 5 && src_log[4] == SRC_UC)
      else report_other("uncached beat went out ahead of an eviction");

    // random mixed traffic with random stalls
    while (n_issued < N_RAND || i_evict_valid || i_uc_valid) begin
      if (!i_evict_valid || ev_fire) begin
        i_evict_valid = 1'b0;
        if (n_issued < N_RAND && rand_bits(2) == 0) begin
          i_evict_valid = 1'b1;
          i_evict_paddr = {28'(rand_bits(28)), 4'h0};
          i_evict_data  = {rand_bits(64), rand_bits(64)};
          n_issued++;
        end
      end
      if (!i_uc_valid || uc_fire) begin
        i_uc_valid = 1'b0;
        if (n_issued < N_RAND && rand_bits(2) == 0) begin
          sz  = mem_size_e'(rand_bits(2));
          ofs = 4'(rand_bits(4)) & ~4'((1 << int'(sz)) - 1);   // natural alignment
          i_uc_valid = 1'b1;
          i_uc_size  = sz;
          i_uc_paddr = {28'(rand_bits(28)), ofs};
          i_uc_data  = rand_bits(64);
          n_issued++;
        end
      end
      i_wr_ready = (rand_bits(2) != 0);
      wait_drive();
    end
    drain();
    repeat (2) wait_drive();

    $display("errors: %0d value, %0d other", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== bench/store_out_asserts.sv ====
`timescale 1ns/1ns

// handshake and holding-slot properties, bound into the requestor and the port
module store_out_asserts (
  input logic         i_clk,
  input logic         i_reset_n,
  input logic         i_hold,      // payload must not move next cycle
  input logic [159:0] i_payload,
  input logic         i_capture,
  input logic         i_release,   // held item leaves on this edge
  input logic         i_out_valid,
  input logic         i_out_flag
);

  logic r_occupied;   // slot state as seen from the handshakes

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_occupied <= 1'b0;
    end else if (i_capture) begin
      r_occupied <= 1'b1;
    end else if (i_release) begin
      r_occupied <= 1'b0;
    end
  end

  // held payload stays put
  payload_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_hold |=> $stable(i_payload))
    else $error("held payload changed under stall");

  // a full slot never takes a new item
  no_capture_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_capture |-> (!r_occupied || i_release))
    else $error("slot captured while full");

  valid_tracks_slot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_out_valid == r_occupied)
    else $error("output valid does not match slot occupancy");

  flag_needs_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_out_flag |-> i_out_valid)
    else $error("last or hit flag without valid");

endmodule

// eviction slot seen through its input and the granted bus
bind store_requestor store_out_asserts u_req_asserts (
  .i_clk       (i_clk),
  .i_reset_n   (i_reset_n),
  .i_hold      (wr_out.valid & ~wr_out.ready & (wr_out.src == SRC_EVICT)),
  .i_payload   ({wr_out.paddr, wr_out.data}),
  .i_capture   (i_evict_valid & o_evict_ready),
  .i_release   (wr_out.valid & wr_out.ready & (wr_out.src == SRC_EVICT)),
  .i_out_valid (wr_out.valid & (wr_out.src == SRC_EVICT)),
  .i_out_flag  (o_fwd_hit)
);

bind ext_write_port store_out_asserts u_port_asserts (
  .i_clk       (i_clk),
  .i_reset_n   (i_reset_n),
  .i_hold      (o_wr_valid & ~i_wr_ready),
  .i_payload   ({54'd0, o_wr_src, o_wr_addr, o_wr_data, o_wr_be, o_wr_last}),
  .i_capture   (wr_in.valid & wr_in.ready),
  .i_release   (o_wr_valid & i_wr_ready & o_wr_last),
  .i_out_valid (o_wr_valid),
  .i_out_flag  (o_wr_last)
);

// ==== design/store_out_unit.sv ====
`timescale 1ns/1ns
`include "lsu_macros.svh"

module store_out_unit
  import lsu_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  // uncached store in
  input  logic                     i_uc_valid,
  output logic                     o_uc_ready,
  input  logic [`PADDR_W-1:0]      i_uc_paddr,
  input  logic [`XLEN_W-1:0]       i_uc_data,
  input  mem_size_e                i_uc_size,

  // eviction in
  input  logic                     i_evict_valid,
  output logic                     o_evict_ready,
  input  logic [`PADDR_W-1:0]      i_evict_paddr,
  input  logic [`LINE_W-1:0]       i_evict_data,

  // load forward
  input  logic                     i_fwd_valid,
  input  logic [`PADDR_W-1:0]      i_fwd_paddr,
  output logic                     o_fwd_hit,
  output logic [`XLEN_W-1:0]       o_fwd_data,
  output logic [`XLEN_W/8-1:0]     o_fwd_be,

  // snoop
  input  logic                     i_snoop_valid,
  input  logic [`PADDR_W-1:0]      i_snoop_paddr,
  output logic                     o_snoop_resp_valid,
  output logic [`LINE_W-1:0]       o_snoop_resp_data,
  output logic [`LINE_BYTES-1:0]   o_snoop_resp_be,

  // external write bus
  output logic                     o_wr_valid,
  output wr_src_e                  o_wr_src,
  output logic [`PADDR_W-1:0]      o_wr_addr,
  output logic [`BEAT_W-1:0]       o_wr_data,
  output logic [`BEAT_W/8-1:0]     o_wr_be,
  output logic                     o_wr_last,
  input  logic                     i_wr_ready
);

  evict_payload_t w_evict;

  uc_store_if u_uc_if ();
  ext_wr_if   u_wr_if ();

  assign w_evict.paddr = i_evict_paddr;
  assign w_evict.data  = i_evict_data;

  uc_store_formatter u_formatter (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_uc_valid (i_uc_valid),
    .o_uc_ready (o_uc_ready),
    .i_uc_paddr (i_uc_paddr),
    .i_uc_data  (i_uc_data),
    .i_uc_size  (i_uc_size),
    .uc_out     (u_uc_if.src)
  );

  store_requestor u_requestor (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_evict_valid      (i_evict_valid),
    .o_evict_ready      (o_evict_ready),
    .i_evict            (w_evict),
    .uc_in              (u_uc_if.dst),
    .wr_out             (u_wr_if.master),
    .i_fwd_valid        (i_fwd_valid),
    .i_fwd_paddr        (i_fwd_paddr),
    .o_fwd_hit          (o_fwd_hit),
    .o_fwd_data         (o_fwd_data),
    .o_fwd_be           (o_fwd_be),
    .i_snoop_valid      (i_snoop_valid),
    .i_snoop_paddr      (i_snoop_paddr),
    .o_snoop_resp_valid (o_snoop_resp_valid),
    .o_snoop_resp_data  (o_snoop_resp_data),
    .o_snoop_resp_be    (o_snoop_resp_be)
  );

  ext_write_port u_wr_port (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .wr_in      (u_wr_if.slave),
    .o_wr_valid (o_wr_valid),
    .o_wr_src   (o_wr_src),
    .o_wr_addr  (o_wr_addr),
    .o_wr_data  (o_wr_data),
    .o_wr_be    (o_wr_be),
    .o_wr_last  (o_wr_last),
    .i_wr_ready (i_wr_ready)
  );

endmodule

// ==== design/ext_write_port.sv ====
`timescale 1ns/1ns
`include "lsu_macros.svh"

module ext_write_port
  import lsu_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  ext_wr_if.slave                  wr_in,

  output logic                     o_wr_valid,
  output wr_src_e                  o_wr_src,
  output logic [`PADDR_W-1:0]      o_wr_addr,
  output logic [`BEAT_W-1:0]       o_wr_data,
  output logic [`BEAT_W/8-1:0]     o_wr_be,
  output logic                     o_wr_last,
  input  logic                     i_wr_ready
);

  localparam int BEAT_BYTES = `BEAT_W/8;
  localparam int BEAT_IDX_W = $clog2(`BEATS_PER_LINE);

  logic                                   r_valid;
  wr_src_e                                r_src;
  logic [`PADDR_W-`LINE_OFS_W-1:0]        r_line;    // line address only
  logic [`LINE_W-1:0]                     r_data;
  logic [`LINE_BYTES-1:0]                 r_byte_en;
  logic [BEAT_IDX_W-1:0]                  r_beat;

  logic [`BEATS_PER_LINE-1:0]             w_held_nz;
  logic                                   w_accept;
  logic                                   w_advance;

  // one flag per beat, set when any of its bytes is written
  function automatic logic [`BEATS_PER_LINE-1:0] beat_nz(input logic [`LINE_BYTES-1:0] be);
    logic [`BEATS_PER_LINE-1:0] nz;
    for (int b = 0; b < `BEATS_PER_LINE; b++) begin
      nz[b] = |be[b*BEAT_BYTES +: BEAT_BYTES];
    end
    return nz;
  endfunction

  // lowest non-empty beat at or above from
  function automatic logic [BEAT_IDX_W-1:0] next_beat(input logic [`BEATS_PER_LINE-1:0] nz,
                                                      input int from);
    logic [BEAT_IDX_W-1:0] idx;
    idx = BEAT_IDX_W'(`BEATS_PER_LINE-1);
    for (int i = `BEATS_PER_LINE-1; i >= 0; i--) begin
      if ((i >= from) && nz[i]) begin
        idx = BEAT_IDX_W'(i);
      end
    end
    return idx;
  endfunction

  assign w_held_nz = beat_nz(r_byte_en);
  // nothing left above the current beat
  assign o_wr_last = r_valid & ~|(w_held_nz >> (int'(r_beat) + 1));

  assign w_advance   = r_valid & i_wr_ready;
  assign wr_in.ready = !r_valid | (w_advance & o_wr_last);
  assign w_accept    = wr_in.valid & wr_in.ready;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
      r_beat  <= '0;
    end else if (w_accept) begin
      r_valid <= 1'b1;
      r_beat  <= next_beat(beat_nz(wr_in.byte_en), 0);   // skip leading empty beats
    end else if (w_advance) begin
      if (o_wr_last) begin
        r_valid <= 1'b0;
      end else begin
        r_beat <= next_beat(w_held_nz, int'(r_beat) + 1);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      r_src     <= wr_in.src;
      r_line    <= wr_in.paddr[`PADDR_W-1:`LINE_OFS_W];
      r_data    <= wr_in.data;
      r_byte_en <= wr_in.byte_en;
    end
  end

  assign o_wr_valid = r_valid;
  assign o_wr_src   = r_src;
  assign o_wr_addr  = {r_line, r_beat, {$clog2(BEAT_BYTES){1'b0}}};
  assign o_wr_data  = r_data[r_beat*`BEAT_W +: `BEAT_W];
  assign o_wr_be    = r_byte_en[r_beat*BEAT_BYTES +: BEAT_BYTES];

endmodule

// ==== design/store_requestor.sv ====
`timescale 1ns/1ns
`include "lsu_macros.svh"

module store_requestor
  import lsu_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  // L1D eviction
  input  logic                     i_evict_valid,
  output logic                     o_evict_ready,
  input  evict_payload_t           i_evict,

  uc_store_if.dst                  uc_in,
  ext_wr_if.master                 wr_out,

  // load forward lookup
  input  logic                     i_fwd_valid,
  input  logic [`PADDR_W-1:0]      i_fwd_paddr,
  output logic                     o_fwd_hit,
  output logic [`XLEN_W-1:0]       o_fwd_data,
  output logic [`XLEN_W/8-1:0]     o_fwd_be,

  // snoop lookup
  input  logic                     i_snoop_valid,
  input  logic [`PADDR_W-1:0]      i_snoop_paddr,
  output logic                     o_snoop_resp_valid,
  output logic [`LINE_W-1:0]       o_snoop_resp_data,
  output logic [`LINE_BYTES-1:0]   o_snoop_resp_be
);

  logic                     r_evict_valid;
  evict_payload_t           r_evict;

  logic                     r_uc_valid;
  logic [`PADDR_W-1:0]      r_uc_paddr;
  logic [`LINE_W-1:0]       r_uc_data;
  logic [`LINE_BYTES-1:0]   r_uc_byte_en;

  wr_src_e                  w_grant;
  logic                     w_fwd_match;
  logic                     w_snoop_match;
  logic [`LINE_W-1:0]       w_fwd_line;

  // ---------------------------------------------------------------------
  // eviction slot
  // ---------------------------------------------------------------------
  assign o_evict_ready = !r_evict_valid;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_evict_valid <= 1'b0;
    end else if (i_evict_valid & o_evict_ready) begin
      r_evict_valid <= 1'b1;
    end else if (r_evict_valid & (w_grant == SRC_EVICT) & wr_out.ready) begin
      r_evict_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_evict_valid & o_evict_ready) begin
      r_evict <= i_evict;
    end
  end

  // ---------------------------------------------------------------------
  // uncached store slot
  // ---------------------------------------------------------------------
  assign uc_in.ready = !r_uc_valid;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_uc_valid <= 1'b0;
    end else if (uc_in.valid & uc_in.ready) begin
      r_uc_valid <= 1'b1;
    end else if (r_uc_valid & (w_grant == SRC_UC) & wr_out.ready) begin
      r_uc_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (uc_in.valid & uc_in.ready) begin
      r_uc_paddr   <= uc_in.paddr;
      r_uc_data    <= uc_in.data;
      r_uc_byte_en <= uc_in.byte_en;
    end
  end

  // ---------------------------------------------------------------------
  // fixed priority, eviction first
  // ---------------------------------------------------------------------
  assign w_grant = r_evict_valid ? SRC_EVICT : SRC_UC;

  always_comb begin
    wr_out.valid = r_evict_valid | r_uc_valid;
    wr_out.src   = w_grant;
    if (w_grant == SRC_EVICT) begin
      wr_out.paddr   = r_evict.paddr;
      wr_out.data    = r_evict.data;
      wr_out.byte_en = {`LINE_BYTES{1'b1}};   // whole line written back
    end else begin
      wr_out.paddr   = r_uc_paddr;
      wr_out.data    = r_uc_data;
      wr_out.byte_en = r_uc_byte_en;
    end
  end

  // ---------------------------------------------------------------------
  // load forward against the waiting eviction
  // ---------------------------------------------------------------------
  assign w_fwd_match = r_evict.paddr[`PADDR_W-1:`LINE_OFS_W] ==
                       i_fwd_paddr[`PADDR_W-1:`LINE_OFS_W];
  assign o_fwd_hit   = i_fwd_valid & r_evict_valid & w_fwd_match;
  assign w_fwd_line  = r_evict.data >> {i_fwd_paddr[`LINE_OFS_W-1:0], 3'b000};
  assign o_fwd_data  = w_fwd_line[`XLEN_W-1:0];
  assign o_fwd_be    = {(`XLEN_W/8){o_fwd_hit}};

  // ---------------------------------------------------------------------
  // snoop, answered one cycle later
  // ---------------------------------------------------------------------
  assign w_snoop_match = r_evict.paddr[`PADDR_W-1:`LINE_OFS_W] ==
                         i_snoop_paddr[`PADDR_W-1:`LINE_OFS_W];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_snoop_resp_valid <= 1'b0;
    end else begin
      o_snoop_resp_valid <= i_snoop_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_snoop_resp_data <= r_evict.data;
    o_snoop_resp_be   <= {`LINE_BYTES{r_evict_valid & w_snoop_match}};
  end

endmodule

// ==== design/uc_store_formatter.sv ====
`timescale 1ns/1ns
`include "lsu_macros.svh"

module uc_store_formatter
  import lsu_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,

  input  logic                i_uc_valid,
  output logic                o_uc_ready,
  input  logic [`PADDR_W-1:0] i_uc_paddr,
  input  logic [`XLEN_W-1:0]  i_uc_data,
  input  mem_size_e           i_uc_size,

  uc_store_if.src             uc_out
);

  logic                     r_valid;
  logic [`PADDR_W-1:0]      r_paddr;
  logic [`LINE_W-1:0]       r_data;
  logic [`LINE_BYTES-1:0]   r_byte_en;

  logic [`LINE_OFS_W-1:0]   w_ofs;
  logic [`LINE_BYTES-1:0]   w_size_be;
  logic                     w_accept;

  assign w_ofs = i_uc_paddr[`LINE_OFS_W-1:0];

  // size opcode to low-aligned enables
  always_comb begin
    case (i_uc_size)
      SIZE_B:  w_size_be = `LINE_BYTES'('h01);
      SIZE_H:  w_size_be = `LINE_BYTES'('h03);
      SIZE_W:  w_size_be = `LINE_BYTES'('h0f);
      default: w_size_be = `LINE_BYTES'('hff);  // SIZE_DW
    endcase
  end

  // take a new store when empty or when the held one leaves this edge
  assign o_uc_ready = !r_valid | uc_out.ready;
  assign w_accept   = i_uc_valid & o_uc_ready;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else if (w_accept) begin
      r_valid <= 1'b1;
    end else if (uc_out.ready) begin
      r_valid <= 1'b0;
    end
  end

  // line-placed payload
  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      r_paddr   <= i_uc_paddr;
      r_byte_en <= w_size_be << w_ofs;
      r_data    <= {{(`LINE_W-`XLEN_W){1'b0}}, i_uc_data} << {w_ofs, 3'b000};
    end
  end

  assign uc_out.valid   = r_valid;
  assign uc_out.paddr   = r_paddr;
  assign uc_out.data    = r_data;
  assign uc_out.byte_en = r_byte_en;

endmodule

// ==== design/store_if.sv ====
`timescale 1ns/1ns
`include "lsu_macros.svh"

// ---------------------------------------------------------------------
// formatted uncached store, formatter to requestor
// ---------------------------------------------------------------------
interface uc_store_if;
  logic                   valid;
  logic                   ready;
  logic [`PADDR_W-1:0]    paddr;
  logic [`LINE_W-1:0]     data;      // already placed in its lane
  logic [`LINE_BYTES-1:0] byte_en;

  modport src (
    output valid, paddr, data, byte_en,
    input  ready
  );

  modport dst (
    input  valid, paddr, data, byte_en,
    output ready
  );
endinterface

// ---------------------------------------------------------------------
// granted line-wide write, requestor to external port
// ---------------------------------------------------------------------
interface ext_wr_if
  import lsu_pkg::*;
();
  logic                   valid;
  logic                   ready;
  wr_src_e                src;       // which slot won the grant
  logic [`PADDR_W-1:0]    paddr;
  logic [`LINE_W-1:0]     data;
  logic [`LINE_BYTES-1:0] byte_en;

  modport master (
    output valid, src, paddr, data, byte_en,
    input  ready
  );

  modport slave (
    input  valid, src, paddr, data, byte_en,
    output ready
  );
endinterface

// ==== design/lsu_pkg.sv ====
`include "lsu_macros.svh"

package lsu_pkg;

  // store size opcode, natural alignment assumed
  typedef enum logic [1:0] {
    SIZE_B  = 2'd0,
    SIZE_H  = 2'd1,
    SIZE_W  = 2'd2,
    SIZE_DW = 2'd3
  } mem_size_e;

  // origin of an external write, sent as the bus tag
  typedef enum logic {
    SRC_EVICT = 1'b0,
    SRC_UC    = 1'b1
  } wr_src_e;

  // dirty line leaving the L1D
  typedef struct packed {
    logic [`PADDR_W-1:0] paddr;   // line address
    logic [`LINE_W-1:0]  data;
  } evict_payload_t;

endpackage

// ==== design/lsu_macros.svh ====
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// ---------------------------------------------------------------------
// line geometry
// ---------------------------------------------------------------------
`define LINE_BYTES      16
`define LINE_W          128
`define LINE_OFS_W      4     // byte offset bits inside a line

// ---------------------------------------------------------------------
// address and bus geometry
// ---------------------------------------------------------------------
`define PADDR_W         32
`define XLEN_W          64
`define BEAT_W          64    // external write bus width
`define BEATS_PER_LINE  2

`endif
